/* flist.f */
+incdir+src
src/corep.sv
src/gbpt_counter_array.sv
src/gbpt_update_pipe.sv
src/gbpt.sv
src/gbpt_wrapper.sv
verification/gbpt_wrapper_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the gbpt testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -f build.log sim.log

verilator --binary --timing -j 0 \
    -f flist.f \
    --top-module gbpt_wrapper_tb \
    --Mdir obj_dir -o gbpt_sim > build.log 2>&1 \
    && ./obj_dir/gbpt_sim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "simulation did not run cleanly"; exit 1; }

cat sim.log
grep -qx "TEST OK" sim.log \
    && { echo "result: pass"; exit 0; } \
    || { echo "result: fail"; exit 1; }

/* verification/gbpt_wrapper_tb.sv */
`timescale 1ns/100ps

module gbpt_wrapper_tb;

    // --------------------
    // run parameters
    // --------------------

    localparam int CLK_PERIOD = 8;
    localparam int RESET_CYCLES = 10;
    // drive edge plus three edges to the registered response
    localparam int READ_CYCLES = 4;
    localparam int RAND_ROUNDS = 40;
    localparam int MAX_BURST = 6;
    // cycles per test, summed
    localparam int TEST_CYCLES = RESET_CYCLES
        + 4 * READ_CYCLES
        + (1 + READ_CYCLES + 2)
        + (7 + 3 * READ_CYCLES)
        + (1 + 3 * READ_CYCLES)
        + (2 + 2 * READ_CYCLES)
        + RAND_ROUNDS * (MAX_BURST + 2 * READ_CYCLES);
    localparam int WATCHDOG_NS = TEST_CYCLES * 2 * CLK_PERIOD + 400;

    // DUT ports
    logic CLK;
    logic nRST;
    corep::ASID_t next_arch_asid;
    logic next_read_req_valid;
    corep::fetch_idx_t next_read_req_fetch_index;
    corep::GH_t next_read_req_gh;
    logic [corep::FETCH_LANES-1:0] last_read_resp_taken_by_lane;
    logic next_update_valid;
    corep::PC38_t next_update_pc38;
    corep::GH_t next_update_gh;
    logic next_update_taken;

    // reference counters, 256 rows by lane
    corep::gbpt_ctr_t model_ctr [256][corep::FETCH_LANES];
    corep::ASID_t cur_asid;

    // bookkeeping
    logic [31:0] rng_state;
    int check_count;
    int error_count;
    int checks_at_start;
    int errors_at_start;
    int test_count;

    gbpt_wrapper gbpt_wrapper_i (
        .CLK(CLK),
        .nRST(nRST),
        .next_arch_asid(next_arch_asid),
        .next_read_req_valid(next_read_req_valid),
        .next_read_req_fetch_index(next_read_req_fetch_index),
        .next_read_req_gh(next_read_req_gh),
        .last_read_resp_taken_by_lane(last_read_resp_taken_by_lane),
        .next_update_valid(next_update_valid),
        .next_update_pc38(next_update_pc38),
        .next_update_gh(next_update_gh),
        .next_update_taken(next_update_taken)
    );

    // --------------------
    // clock and watchdog
    // --------------------

    initial begin
        CLK = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) CLK = ~CLK;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired, tests did not complete in time");
        $display("TEST FAILED");
        $finish;
    end

    // --------------------
    // reference model
    // --------------------

    // lcg, upper bits are the useful ones
    function automatic logic [15:0] next_rand();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state[30:15];
    endfunction

    // row = fidx ^ gh lo ^ (gh hi << 4) ^ asid, all 8 bits
    function automatic corep::gbpt_idx_t hash_row(
        input corep::fetch_idx_t fidx,
        input corep::GH_t gh,
        input corep::ASID_t asid
    );
        logic [7:0] r;
        r = fidx[7:0] ^ gh[7:0] ^ {gh[11:8], 4'b0000} ^ asid[7:0];
        return r;
    endfunction

    // saturating step toward the outcome
    task automatic apply_to_model(input corep::gbpt_idx_t row, input corep::lane_t lane,
                                  input logic taken);
        if (taken && model_ctr[row][lane] != 2'b11) begin
            model_ctr[row][lane] = model_ctr[row][lane] + 2'b01;
        end else if (!taken && model_ctr[row][lane] != 2'b00) begin
            model_ctr[row][lane] = model_ctr[row][lane] - 2'b01;
        end
    endtask

    // taken bit per lane is the counter msb
    function automatic logic [corep::FETCH_LANES-1:0] model_prediction(
        input corep::fetch_idx_t fidx,
        input corep::GH_t gh,
        input corep::ASID_t asid
    );
        logic [corep::FETCH_LANES-1:0] taken;
        corep::gbpt_idx_t row;
        row = hash_row(fidx, gh, asid);
        for (int l = 0; l < corep::FETCH_LANES; l++) begin
            taken[l] = model_ctr[row][l][1];
        end
        return taken;
    endfunction

    // --------------------
    // drive and check
    // --------------------

    task automatic compare_taken(input string what, input logic [corep::FETCH_LANES-1:0] got,
                                 input logic [corep::FETCH_LANES-1:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("error: last_read_resp_taken_by_lane (%s) got %h expected %h",
                     what, got, exp);
        end
    endtask

    task automatic drive_idle();
        @(negedge CLK);
        next_update_valid = 1'b0;
        next_read_req_valid = 1'b0;
        next_arch_asid = cur_asid;
    endtask

    // one update per call, model follows at once
    task automatic drive_update(input corep::fetch_idx_t fidx, input corep::lane_t lane,
                                input corep::GH_t gh, input logic taken);
        logic [15:0] hi;
        @(negedge CLK);
        hi = next_rand();
        next_read_req_valid = 1'b0;
        next_update_valid = 1'b1;
        // upper pc bits are noise to the table
        next_update_pc38 = {hi, hi[8:0], fidx, lane};
        next_update_gh = gh;
        next_update_taken = taken;
        apply_to_model(hash_row(fidx, gh, cur_asid), lane, taken);
    endtask

    // response is registered two edges after the sampling edge
    task automatic read_and_check(input string what, input corep::fetch_idx_t fidx,
                                  input corep::GH_t gh,
                                  output logic [corep::FETCH_LANES-1:0] got);
        logic [corep::FETCH_LANES-1:0] exp;
        @(negedge CLK);
        next_update_valid = 1'b0;
        next_read_req_valid = 1'b1;
        next_read_req_fetch_index = fidx;
        next_read_req_gh = gh;
        exp = model_prediction(fidx, gh, cur_asid);
        @(negedge CLK);
        next_read_req_valid = 1'b0;
        @(negedge CLK);
        @(negedge CLK);
        got = last_read_resp_taken_by_lane;
        compare_taken(what, got, exp);
    endtask

    task automatic report_test(input string name);
        test_count++;
        $display("%s: %0d checks, %0d errors", name, check_count - checks_at_start,
                 error_count - errors_at_start);
        checks_at_start = check_count;
        errors_at_start = error_count;
    endtask

    // --------------------
    // directed tests
    // --------------------

    task automatic reset_reads_not_taken();
        logic [corep::FETCH_LANES-1:0] got;
        for (int i = 0; i < 4; i++) begin
            read_and_check("after reset", corep::fetch_idx_t'(next_rand()),
                           corep::GH_t'(next_rand()), got);
            compare_taken("after reset all lanes", got, '0);
        end
        report_test("reset_reads_not_taken");
    endtask

    task automatic single_update_trains_lane();
        logic [corep::FETCH_LANES-1:0] got;
        logic [corep::FETCH_LANES-1:0] one_hot;
        one_hot = '0;
        one_hot[5] = 1'b1;
        drive_update(10'h021, 3'd5, 12'h3C4, 1'b1);
        read_and_check("single taken", 10'h021, 12'h3C4, got);
        compare_taken("single taken lane 5 only", got, one_hot);
        // no read issued, answer must hold
        drive_idle();
        drive_idle();
        compare_taken("held response", last_read_resp_taken_by_lane, one_hot);
        report_test("single_update_trains_lane");
    endtask

    task automatic counter_saturates();
        logic [corep::FETCH_LANES-1:0] got;
        // 01 -> 10 -> 11 -> 11, then 10
        drive_update(10'h2E7, 3'd1, 12'h0B0, 1'b1);
        drive_update(10'h2E7, 3'd1, 12'h0B0, 1'b1);
        drive_update(10'h2E7, 3'd1, 12'h0B0, 1'b1);
        drive_update(10'h2E7, 3'd1, 12'h0B0, 1'b0);
        read_and_check("saturated then one nt", 10'h2E7, 12'h0B0, got);
        compare_taken("still taken", got & 8'h02, 8'h02);
        // 10 -> 01, still taken here if 11 had wrapped
        drive_update(10'h2E7, 3'd1, 12'h0B0, 1'b0);
        read_and_check("one more nt", 10'h2E7, 12'h0B0, got);
        compare_taken("top held at 11", got & 8'h02, 8'h00);
        // 01 -> 00 -> 00, floor holds
        drive_update(10'h2E7, 3'd1, 12'h0B0, 1'b0);
        drive_update(10'h2E7, 3'd1, 12'h0B0, 1'b0);
        read_and_check("nt at the floor", 10'h2E7, 12'h0B0, got);
        compare_taken("back to not-taken", got & 8'h02, 8'h00);
        report_test("counter_saturates");
    endtask

    task automatic hash_alias_shares_row();
        logic [corep::FETCH_LANES-1:0] got;
        drive_update(10'h155, 3'd2, 12'h9A3, 1'b1);
        read_and_check("trained gh", 10'h155, 12'h9A3, got);
        compare_taken("trained lane 2 only", got, 8'h04);
        // same xor on fidx and gh low bits cancels out
        read_and_check("aliased fidx and gh", 10'h155 ^ 10'h00C, 12'h9A3 ^ 12'h00C, got);
        compare_taken("alias matches", got, 8'h04);
        // gh high slice moves the row
        read_and_check("different gh", 10'h155, 12'h9A3 ^ 12'h100, got);
        compare_taken("different gh misses", got & 8'h04, 8'h00);
        report_test("hash_alias_shares_row");
    endtask

    task automatic asid_change_moves_row();
        logic [corep::FETCH_LANES-1:0] got;
        cur_asid = 9'h1A5;
        drive_idle();
        read_and_check("old index new asid", 10'h021, 12'h3C4, got);
        // fidx compensates the asid, lands on the lane 5 row
        read_and_check("asid folded back", 10'h021 ^ 10'h0A5, 12'h3C4, got);
        compare_taken("trained row reached", got & 8'h20, 8'h20);
        cur_asid = '0;
        drive_idle();
        report_test("asid_change_moves_row");
    endtask

    task automatic random_update_bursts();
        logic [corep::FETCH_LANES-1:0] got;
        corep::fetch_idx_t pool_fidx [4];
        corep::GH_t pool_gh [4];
        corep::fetch_idx_t fidx;
        corep::GH_t gh;
        corep::lane_t lane;
        logic taken;
        logic [15:0] r;
        int burst;
        // small pool so counters collide often
        for (int p = 0; p < 4; p++) begin
            pool_fidx[p] = corep::fetch_idx_t'(next_rand());
            pool_gh[p] = corep::GH_t'(next_rand());
        end
        fidx = pool_fidx[0];
        gh = pool_gh[0];
        lane = '0;
        for (int round = 0; round < RAND_ROUNDS; round++) begin
            r = next_rand();
            burst = 1 + int'(r % MAX_BURST);
            for (int k = 0; k < burst; k++) begin
                r = next_rand();
                // keep the same counter one time in four
                if (k == 0 || r[1:0] != 2'b00) begin
                    fidx = pool_fidx[r[3:2]];
                    gh = pool_gh[r[5:4]];
                    lane = r[8:6];
                end
                taken = r[9];
                drive_update(fidx, lane, gh, taken);
            end
            read_and_check("burst last counter", fidx, gh, got);
            r = next_rand();
            if (r[0]) begin
                read_and_check("burst pool row", pool_fidx[r[2:1]], pool_gh[r[4:3]], got);
            end
        end
        report_test("random_update_bursts");
    endtask

    // --------------------
    // main sequence
    // --------------------

    initial begin
        rng_state = 32'd10;
        check_count = 0;
        error_count = 0;
        checks_at_start = 0;
        errors_at_start = 0;
        test_count = 0;
        cur_asid = '0;
        for (int r = 0; r < 256; r++) begin
            for (int l = 0; l < corep::FETCH_LANES; l++) begin
                model_ctr[r][l] = 2'b01;
            end
        end

        nRST = 1'b0;
        next_arch_asid = '0;
        next_read_req_valid = 1'b0;
        next_read_req_fetch_index = '0;
        next_read_req_gh = '0;
        next_update_valid = 1'b0;
        next_update_pc38 = '0;
        next_update_gh = '0;
        next_update_taken = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;

        reset_reads_not_taken();
        single_update_trains_lane();
        counter_saturates();
        hash_alias_shares_row();
        asid_change_moves_row();
        random_update_bursts();

        $display("summary: %0d tests, %0d checks, %0d errors", test_count, check_count,
                 error_count);
        if (error_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* src/gbpt_wrapper.sv */
`timescale 1ns/100ps

module gbpt_wrapper (
    // clock and reset
    input logic CLK,
    input logic nRST,

    // arch state
    input corep::ASID_t next_arch_asid,

    // read request
    input logic next_read_req_valid,
    input corep::fetch_idx_t next_read_req_fetch_index,
    input corep::GH_t next_read_req_gh,

    // read response
    output logic [corep::FETCH_LANES-1:0] last_read_resp_taken_by_lane,

    // update
    input logic next_update_valid,
    input corep::PC38_t next_update_pc38,
    input corep::GH_t next_update_gh,
    input logic next_update_taken
);

    // --------------------
    // registered side of gbpt
    // --------------------

    // arch state
    corep::ASID_t arch_asid;

    // read request
    logic read_req_valid;
    corep::fetch_idx_t read_req_fetch_index;
    corep::GH_t read_req_gh;

    // read response
    logic [corep::FETCH_LANES-1:0] read_resp_taken_by_lane;

    // update
    logic update_valid;
    corep::PC38_t update_pc38;
    corep::GH_t update_gh;
    logic update_taken;

    // --------------------
    // table
    // --------------------

    gbpt gbpt_i (
        .CLK(CLK),
        .nRST(nRST),
        .arch_asid(arch_asid),
        .read_req_valid(read_req_valid),
        .read_req_fetch_index(read_req_fetch_index),
        .read_req_gh(read_req_gh),
        .read_resp_taken_by_lane(read_resp_taken_by_lane),
        .update_valid(update_valid),
        .update_pc38(update_pc38),
        .update_gh(update_gh),
        .update_taken(update_taken)
    );

    // --------------------
    // boundary flops
    // --------------------

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            // arch state
            arch_asid <= '0;
            // read request
            read_req_valid <= 1'b0;
            read_req_fetch_index <= '0;
            read_req_gh <= '0;
            // read response
            last_read_resp_taken_by_lane <= '0;
            // update
            update_valid <= 1'b0;
            update_pc38 <= '0;
            update_gh <= '0;
            update_taken <= 1'b0;
        end else begin
            // arch state
            arch_asid <= next_arch_asid;
            // read request
            read_req_valid <= next_read_req_valid;
            read_req_fetch_index <= next_read_req_fetch_index;
            read_req_gh <= next_read_req_gh;
            // read response
            last_read_resp_taken_by_lane <= read_resp_taken_by_lane;
            // update
            update_valid <= next_update_valid;
            update_pc38 <= next_update_pc38;
            update_gh <= next_update_gh;
            update_taken <= next_update_taken;
        end
    end

endmodule

/* src/gbpt.sv */
`timescale 1ns/100ps

module gbpt (
    input logic CLK,
    input logic nRST,

    // arch state
    input corep::ASID_t arch_asid,

    // read request
    input logic read_req_valid,
    input corep::fetch_idx_t read_req_fetch_index,
    input corep::GH_t read_req_gh,

    // read response, one cycle after the request
    output logic [corep::FETCH_LANES-1:0] read_resp_taken_by_lane,

    // update from retire
    input logic update_valid,
    input corep::PC38_t update_pc38,
    input corep::GH_t update_gh,
    input logic update_taken
);

    // hashed rows
    corep::gbpt_idx_t read_idx;
    corep::gbpt_idx_t upd_idx;

    // update pc split
    corep::fetch_idx_t upd_fetch_index;
    corep::lane_t upd_lane;

    // array <-> pipe
    corep::gbpt_row_t pred_row;
    corep::gbpt_idx_t upd_rd_idx;
    corep::gbpt_row_t upd_rd_row;
    logic wr_en;
    corep::gbpt_idx_t wr_idx;
    corep::lane_t wr_lane;
    corep::gbpt_ctr_t wr_ctr;

    // response stage
    logic read_resp_valid;
    logic [corep::FETCH_LANES-1:0] held_taken_by_lane;

    // --------------------
    // index hash
    // --------------------

    // fold fetch index, both gh slices and asid into one row
    function automatic corep::gbpt_idx_t hash_idx(
        input corep::fetch_idx_t fetch_index,
        input corep::GH_t gh,
        input corep::ASID_t asid
    );
        corep::gbpt_idx_t gh_hi;
        gh_hi = corep::gbpt_idx_t'(gh[11:8]) << 4;
        return fetch_index[7:0] ^ gh[7:0] ^ gh_hi ^ asid[7:0];
    endfunction

    assign read_idx = hash_idx(read_req_fetch_index, read_req_gh, arch_asid);

    // lane in [2:0], fetch index just above
    assign upd_lane = update_pc38[2:0];
    assign upd_fetch_index = update_pc38[12:3];
    assign upd_idx = hash_idx(upd_fetch_index, update_gh, arch_asid);

    // --------------------
    // storage and update
    // --------------------

    gbpt_counter_array counter_array_i (
        .CLK(CLK),
        .nRST(nRST),
        .pred_idx(read_idx),
        .pred_row(pred_row),
        .upd_rd_idx(upd_rd_idx),
        .upd_rd_row(upd_rd_row),
        .wr_en(wr_en),
        .wr_idx(wr_idx),
        .wr_lane(wr_lane),
        .wr_ctr(wr_ctr)
    );

    gbpt_update_pipe update_pipe_i (
        .CLK(CLK),
        .nRST(nRST),
        .upd_valid(update_valid),
        .upd_idx(upd_idx),
        .upd_lane(upd_lane),
        .upd_taken(update_taken),
        .rd_idx(upd_rd_idx),
        .rd_row(upd_rd_row),
        .wr_en(wr_en),
        .wr_idx(wr_idx),
        .wr_lane(wr_lane),
        .wr_ctr(wr_ctr)
    );

    // --------------------
    // read response
    // --------------------

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            read_resp_valid <= 1'b0;
            held_taken_by_lane <= '0;
        end else begin
            read_resp_valid <= read_req_valid;
            held_taken_by_lane <= read_resp_taken_by_lane;
        end
    end

    // counter msb is the prediction; keep old answer with no read
    always_comb begin
        read_resp_taken_by_lane = held_taken_by_lane;
        if (read_resp_valid) begin
            for (int l = 0; l < corep::FETCH_LANES; l++) begin
                read_resp_taken_by_lane[l] = pred_row[l][1];
            end
        end
    end

endmodule

/* src/gbpt_update_pipe.sv */
`timescale 1ns/100ps

module gbpt_update_pipe (
    input logic CLK,
    input logic nRST,

    // decoded update from gbpt
    input logic upd_valid,
    input corep::gbpt_idx_t upd_idx,
    input corep::lane_t upd_lane,
    input logic upd_taken,

    // array update read port
    output corep::gbpt_idx_t rd_idx,
    input corep::gbpt_row_t rd_row,

    // array write port
    output logic wr_en,
    output corep::gbpt_idx_t wr_idx,
    output corep::lane_t wr_lane,
    output corep::gbpt_ctr_t wr_ctr
);

    // stage 2 state
    logic s2_valid;
    corep::gbpt_idx_t s2_idx;
    corep::lane_t s2_lane;
    logic s2_taken;

    // forwarded counter from the write that passed stage 1
    logic s2_fwd;
    corep::gbpt_ctr_t s2_fwd_ctr;

    // stage 1 hits the counter being written this cycle
    logic s1_hit;

    // counter before and after saturation
    corep::gbpt_ctr_t s2_old_ctr;
    corep::gbpt_ctr_t s2_new_ctr;

    // --------------------
    // stage 1
    // --------------------

    // read issued straight from the decoded update
    assign rd_idx = upd_idx;

    // array read on this edge misses the write, so catch it here
    assign s1_hit = wr_en && (wr_idx == upd_idx) && (wr_lane == upd_lane);

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            s2_valid <= 1'b0;
            s2_fwd <= 1'b0;
        end else begin
            s2_valid <= upd_valid;
            s2_fwd <= upd_valid & s1_hit;
        end
    end

    // payload
    always_ff @(posedge CLK) begin
        s2_idx <= upd_idx;
        s2_lane <= upd_lane;
        s2_taken <= upd_taken;
        s2_fwd_ctr <= wr_ctr;
    end

    // --------------------
    // stage 2
    // --------------------

    always_comb begin
        // pick lane counter, newer write wins
        if (s2_fwd) begin
            s2_old_ctr = s2_fwd_ctr;
        end else begin
            s2_old_ctr = rd_row[s2_lane];
        end

        // saturate at 0 and 3
        s2_new_ctr = s2_old_ctr;
        if (s2_taken) begin
            if (s2_old_ctr != 2'b11) begin
                s2_new_ctr = s2_old_ctr + 2'b01;
            end
        end else begin
            if (s2_old_ctr != 2'b00) begin
                s2_new_ctr = s2_old_ctr - 2'b01;
            end
        end
    end

    // single-counter write
    assign wr_en = s2_valid;
    assign wr_idx = s2_idx;
    assign wr_lane = s2_lane;
    assign wr_ctr = s2_new_ctr;

endmodule

/* src/gbpt_counter_array.sv */
`timescale 1ns/100ps

module gbpt_counter_array (
    input logic CLK,
    input logic nRST,

    // prediction read port
    input corep::gbpt_idx_t pred_idx,
    output corep::gbpt_row_t pred_row,

    // update read port
    input corep::gbpt_idx_t upd_rd_idx,
    output corep::gbpt_row_t upd_rd_row,

    // single-counter write port
    input logic wr_en,
    input corep::gbpt_idx_t wr_idx,
    input corep::lane_t wr_lane,
    input corep::gbpt_ctr_t wr_ctr
);

    // one row per hashed index
    localparam int ROWS = 1 << $bits(corep::gbpt_idx_t);
    // every lane weakly not-taken
    localparam corep::gbpt_row_t ROW_RESET = {corep::FETCH_LANES{corep::GBPT_CTR_WEAK_NT}};

    corep::gbpt_row_t rows [ROWS];

    // target row with the new counter merged in
    corep::gbpt_row_t wr_row_merged;

    // --------------------
    // write merge
    // --------------------

    always_comb begin
        wr_row_merged = rows[wr_idx];
        wr_row_merged[wr_lane] = wr_ctr;
    end

    // --------------------
    // storage
    // --------------------

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            for (int r = 0; r < ROWS; r++) begin
                rows[r] <= ROW_RESET;
            end
        end else if (wr_en) begin
            rows[wr_idx] <= wr_row_merged;
        end
    end

    // --------------------
    // read ports
    // --------------------

    // prediction port is write-first
    // update port sees the old row, the pipe forwards instead
    always_ff @(posedge CLK) begin
        if (wr_en && (wr_idx == pred_idx)) begin
            pred_row <= wr_row_merged;
        end else begin
            pred_row <= rows[pred_idx];
        end
        upd_rd_row <= rows[upd_rd_idx];
    end

endmodule

/* src/corep.sv */
`include "gbpt_cfg.svh"

package corep;

    // --------------------
    // fetch geometry
    // --------------------

    // lanes per fetch block
    localparam int FETCH_LANES = `GBPT_FETCH_LANES;

    // --------------------
    // core state types
    // --------------------

    typedef logic [`GBPT_ASID_BITS-1:0] ASID_t;
    typedef logic [`GBPT_FETCH_IDX_BITS-1:0] fetch_idx_t;
    typedef logic [`GBPT_GH_BITS-1:0] GH_t;
    // lane in [2:0], fetch index in [12:3]
    typedef logic [`GBPT_PC_BITS-1:0] PC38_t;

    // --------------------
    // predictor types
    // --------------------

    typedef logic [`GBPT_INDEX_BITS-1:0] gbpt_idx_t;
    typedef logic [`GBPT_LANE_BITS-1:0] lane_t;
    // 00 strong nt, 01 weak nt, 10 weak t, 11 strong t
    typedef logic [1:0] gbpt_ctr_t;
    // one counter per lane, lane 0 in the low bits
    typedef gbpt_ctr_t [FETCH_LANES-1:0] gbpt_row_t;

    // weakly not-taken, the reset state of every counter
    localparam gbpt_ctr_t GBPT_CTR_WEAK_NT = 2'b01;

endpackage

/* src/gbpt_cfg.svh */
`ifndef GBPT_CFG_SVH
`define GBPT_CFG_SVH

// --------------------
// fetch block geometry
// --------------------

// lanes per fetch block, one counter each
`define GBPT_FETCH_LANES 8
// lane number width
`define GBPT_LANE_BITS 3

// --------------------
// table sizing
// --------------------

// hashed row index, 256 rows
`define GBPT_INDEX_BITS 8

// --------------------
// core-side widths
// --------------------

// fetch block index
`define GBPT_FETCH_IDX_BITS 10
// global history
`define GBPT_GH_BITS 12
// address-space id
`define GBPT_ASID_BITS 9
// pc counted in 2-byte parcels
`define GBPT_PC_BITS 38

`endif
